/* design/mmio_memory_pkg.sv */
package mmio_memory_pkg;

    // Default geometry of the data memory
    localparam int unsigned word_width_default = 16;
    localparam int unsigned addr_width_default = 8;

    // Input ports sit at F9..FB, away from any power-of-two boundary
    localparam int unsigned io_read_count_default = 3;
    localparam logic [addr_width_default-1:0] io_read_base_default = 8'hF9;

    // Output ports sit at FD..FF
    localparam int unsigned io_write_count_default = 3;
    localparam logic [addr_width_default-1:0] io_write_base_default = 8'hFD;

    // True when addr lies in [base, base + count)
    function automatic logic in_window(
        input int unsigned addr,
        input int unsigned base,
        input int unsigned count
    );
        logic hit;
        hit = 1'b0;
        if (addr >= base) begin
            hit = ((addr - base) < count);
        end
        return hit;
    endfunction

    // Port number of an address inside its window
    // Outside the window the result is meaningless and never matches a real port
    // when the address is below the base, as the subtraction wraps high
    function automatic int unsigned port_index(
        input int unsigned addr,
        input int unsigned base
    );
        int unsigned index;
        index = addr - base;
        return index;
    endfunction

endpackage

/* design/mem_write_decode.sv */
`timescale 1ns/100ps

module mem_write_decode #(
    parameter int unsigned word_width     = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width     = mmio_memory_pkg::addr_width_default,
    parameter int unsigned io_write_count = mmio_memory_pkg::io_write_count_default,
    parameter int unsigned io_write_base  = mmio_memory_pkg::io_write_base_default
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               wren,
    input  logic [addr_width-1:0]              write_addr,
    input  logic [word_width-1:0]              write_data,
    output logic                               ram_wren,
    output logic [addr_width-1:0]              ram_write_addr,
    output logic [word_width-1:0]              ram_write_data,
    output logic [io_write_count-1:0]          io_wren,
    output logic [word_width*io_write_count-1:0] io_out
);

    logic                      write_in_window;
    int unsigned               write_port;
    logic [io_write_count-1:0] wren_onehot;

    // Window decode on the raw request address
    always_comb begin
        write_in_window = mmio_memory_pkg::in_window(
            32'(write_addr),
            io_write_base,
            io_write_count
        );
        write_port = mmio_memory_pkg::port_index(32'(write_addr), io_write_base);
    end

    // One enable per output port, only the addressed one may rise
    always_comb begin
        wren_onehot = '0;
        for (int unsigned p = 0; p < io_write_count; p++) begin
            if (wren && write_in_window && (write_port == p)) begin
                wren_onehot[p] = 1'b1;
            end
        end
    end

    // RAM write pass-through, one cycle late
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ram_wren       <= 1'b0;
            ram_write_addr <= '0;
            ram_write_data <= '0;
        end else begin
            ram_wren       <= wren;
            ram_write_addr <= write_addr;
            ram_write_data <= write_data;
        end
    end

    // I/O writes also land in RAM through the path above
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_wren <= '0;
        end else begin
            io_wren <= wren_onehot;
        end
    end

    // Same word on every output slot, the enables pick the consumer
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_out <= '0;
        end else begin
            io_out <= {io_write_count{write_data}};
        end
    end

endmodule

/* design/mem_ram.sv */
`timescale 1ns/100ps

module mem_ram #(
    parameter int unsigned word_width = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width = mmio_memory_pkg::addr_width_default
) (
    input  logic                  clock,
    input  logic                  wren,
    input  logic [addr_width-1:0] write_addr,
    input  logic [word_width-1:0] write_data,
    input  logic [addr_width-1:0] read_addr,
    output logic [word_width-1:0] read_data
);

    localparam int unsigned depth = 2 ** addr_width;

    logic [word_width-1:0] mem [depth];
    logic                  same_addr;

    assign same_addr = wren && (write_addr == read_addr);

    // Write and registered read share one block
    // A read of the address being written returns the new word
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
        if (same_addr) begin
            read_data <= write_data;
        end else begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* design/mem_read_result.sv */
`timescale 1ns/100ps

module mem_read_result #(
    parameter int unsigned word_width    = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width    = mmio_memory_pkg::addr_width_default,
    parameter int unsigned io_read_count = mmio_memory_pkg::io_read_count_default,
    parameter int unsigned io_read_base  = mmio_memory_pkg::io_read_base_default
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [addr_width-1:0]               read_addr,
    input  logic [word_width-1:0]               read_data_ram,
    input  logic [word_width*io_read_count-1:0] io_in,
    output logic [word_width-1:0]               read_data,
    output logic [io_read_count-1:0]            io_rden
);

    int unsigned               read_port;
    logic [word_width-1:0]     io_word;
    logic [word_width-1:0]     io_word_q;
    logic [addr_width-1:0]     read_addr_q;
    logic                      addr_q_in_window;
    int unsigned               read_port_q;
    logic [io_read_count-1:0]  rden_onehot;

    // Stage 1: pick the input port word by its offset from the window base
    always_comb begin
        read_port = mmio_memory_pkg::port_index(32'(read_addr), io_read_base);
        io_word   = '0;
        for (int unsigned p = 0; p < io_read_count; p++) begin
            if (read_port == p) begin
                io_word = io_in[p*word_width +: word_width];
            end
        end
    end

    // Sample the port word and the address alongside the RAM read
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_word_q   <= '0;
            read_addr_q <= '0;
        end else begin
            io_word_q   <= io_word;
            read_addr_q <= read_addr;
        end
    end

    // Stage 2 decode on the delayed address
    always_comb begin
        addr_q_in_window = mmio_memory_pkg::in_window(
            32'(read_addr_q),
            io_read_base,
            io_read_count
        );
        read_port_q = mmio_memory_pkg::port_index(32'(read_addr_q), io_read_base);
    end

    always_comb begin
        rden_onehot = '0;
        for (int unsigned p = 0; p < io_read_count; p++) begin
            if (addr_q_in_window && (read_port_q == p)) begin
                rden_onehot[p] = 1'b1;
            end
        end
    end

    // I/O word wins over the RAM word inside the read window
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (addr_q_in_window) begin
            read_data <= io_word_q;
        end else begin
            read_data <= read_data_ram;
        end
    end

    // Read enable pulses together with the returned word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_rden <= '0;
        end else begin
            io_rden <= rden_onehot;
        end
    end

endmodule

/* design/mmio_memory.sv */
`timescale 1ns/100ps

module mmio_memory #(
    parameter int unsigned word_width     = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width     = mmio_memory_pkg::addr_width_default,
    parameter int unsigned io_read_count  = mmio_memory_pkg::io_read_count_default,
    parameter int unsigned io_read_base   = mmio_memory_pkg::io_read_base_default,
    parameter int unsigned io_write_count = mmio_memory_pkg::io_write_count_default,
    parameter int unsigned io_write_base  = mmio_memory_pkg::io_write_base_default
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 wren,
    input  logic [addr_width-1:0]                write_addr,
    input  logic [word_width-1:0]                write_data,
    input  logic [addr_width-1:0]                read_addr,
    input  logic [word_width*io_read_count-1:0]  io_in,
    output logic [word_width-1:0]                read_data,
    output logic [io_read_count-1:0]             io_rden,
    output logic [io_write_count-1:0]            io_wren,
    output logic [word_width*io_write_count-1:0] io_out
);

    // Registered write request toward the RAM
    logic                  ram_wren;
    logic [addr_width-1:0] ram_write_addr;
    logic [word_width-1:0] ram_write_data;

    logic [word_width-1:0] read_data_ram;

    mem_write_decode #(
        .word_width     (word_width),
        .addr_width     (addr_width),
        .io_write_count (io_write_count),
        .io_write_base  (io_write_base)
    ) u_write_decode (
        .clock          (clock),
        .rst_n          (rst_n),
        .wren           (wren),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .ram_wren       (ram_wren),
        .ram_write_addr (ram_write_addr),
        .ram_write_data (ram_write_data),
        .io_wren        (io_wren),
        .io_out         (io_out)
    );

    mem_ram #(
        .word_width (word_width),
        .addr_width (addr_width)
    ) u_ram (
        .clock      (clock),
        .wren       (ram_wren),
        .write_addr (ram_write_addr),
        .write_data (ram_write_data),
        .read_addr  (read_addr),
        .read_data  (read_data_ram)
    );

    mem_read_result #(
        .word_width    (word_width),
        .addr_width    (addr_width),
        .io_read_count (io_read_count),
        .io_read_base  (io_read_base)
    ) u_read_result (
        .clock         (clock),
        .rst_n         (rst_n),
        .read_addr     (read_addr),
        .read_data_ram (read_data_ram),
        .io_in         (io_in),
        .read_data     (read_data),
        .io_rden       (io_rden)
    );

endmodule

/* tb/mmio_memory_props.sv */
`timescale 1ns/100ps

module mmio_memory_props #(
    parameter int unsigned word_width    = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width    = mmio_memory_pkg::addr_width_default,
    parameter int unsigned io_read_count = mmio_memory_pkg::io_read_count_default,
    parameter int unsigned io_read_base  = mmio_memory_pkg::io_read_base_default
) (
    input logic                     clock,
    input logic                     rst_n,
    input logic [addr_width-1:0]    read_addr,
    input logic [word_width-1:0]    read_data,
    input logic [io_read_count-1:0] io_rden
);

    logic read_in_window;

    assign read_in_window = (32'(read_addr) >= io_read_base)
                         && (32'(read_addr) < io_read_base + io_read_count);

    // At most one input port is read per cycle
    rden_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(io_rden))
        else $error("io_rden has more than one bit set");

    rden_reset: assert property (@(posedge clock) !rst_n |=> (io_rden == '0))
        else $error("io_rden is not cleared after reset");

    io_read_known: assert property (@(posedge clock) disable iff (!rst_n)
        read_in_window |-> ##2 !$isunknown(read_data))
        else $error("read_data is unknown two cycles after an input port read");

endmodule

bind mem_read_result mmio_memory_props #(
    .word_width    (word_width),
    .addr_width    (addr_width),
    .io_read_count (io_read_count),
    .io_read_base  (io_read_base)
) u_props (
    .clock     (clock),
    .rst_n     (rst_n),
    .read_addr (read_addr),
    .read_data (read_data),
    .io_rden   (io_rden)
);

/* tb/mmio_memory_checker.sv */
`timescale 1ns/100ps

module mmio_memory_checker #(
    parameter int unsigned word_width     = mmio_memory_pkg::word_width_default,
    parameter int unsigned addr_width     = mmio_memory_pkg::addr_width_default,
    parameter int unsigned io_read_count  = mmio_memory_pkg::io_read_count_default,
    parameter int unsigned io_read_base   = mmio_memory_pkg::io_read_base_default,
    parameter int unsigned io_write_count = mmio_memory_pkg::io_write_count_default,
    parameter int unsigned io_write_base  = mmio_memory_pkg::io_write_base_default
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 wren,
    input  logic [addr_width-1:0]                write_addr,
    input  logic [word_width-1:0]                write_data,
    input  logic [addr_width-1:0]                read_addr,
    input  logic [word_width*io_read_count-1:0]  io_in,
    input  logic [word_width-1:0]                read_data,
    input  logic [io_read_count-1:0]             io_rden,
    input  logic [io_write_count-1:0]            io_wren,
    input  logic [word_width*io_write_count-1:0] io_out,
    output int unsigned                          error_count,
    output int unsigned                          read_checks
);

    localparam int unsigned depth = 2 ** addr_width;
    localparam logic [addr_width-1:0] read_lo  = addr_width'(io_read_base);
    localparam logic [addr_width-1:0] read_hi  = addr_width'(io_read_base + io_read_count - 1);
    localparam logic [addr_width-1:0] write_lo = addr_width'(io_write_base);
    localparam logic [addr_width-1:0] write_hi = addr_width'(io_write_base + io_write_count - 1);

    logic [word_width-1:0]                model_mem [depth];
    bit                                   model_written [depth];
    int unsigned                          errors;
    int unsigned                          reads_compared;
    int unsigned                          port;

    // Read after the first edge
    logic [word_width-1:0]                s1_data;
    bit                                   s1_known;
    logic [io_read_count-1:0]             s1_rden;

    // Values the DUT should show after the current edge
    bit                                   exp_valid;
    logic [word_width-1:0]                exp_read_data;
    bit                                   exp_read_known;
    logic [io_read_count-1:0]             exp_io_rden;
    logic [io_write_count-1:0]            exp_io_wren;
    logic [word_width*io_write_count-1:0] exp_io_out;

    assign error_count = errors;
    assign read_checks = reads_compared;

    task automatic mismatch(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        errors++;
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    // Outputs seen here are the ones registered at the previous edge
    always @(posedge clock) begin
        if (exp_valid) begin
            if (io_wren !== exp_io_wren) mismatch("io_wren", 64'(exp_io_wren), 64'(io_wren));
            if (io_out !== exp_io_out) mismatch("io_out", 64'(exp_io_out), 64'(io_out));
            if (io_rden !== exp_io_rden) mismatch("io_rden", 64'(exp_io_rden), 64'(io_rden));
        end
        if (exp_read_known) begin
            reads_compared++;
            if (read_data !== exp_read_data) begin
                mismatch("read_data", 64'(exp_read_data), 64'(read_data));
            end
        end

        if (!rst_n) begin
            exp_valid      = 1'b1;
            exp_read_data  = '0;
            exp_read_known = 1'b1;
            exp_io_rden    = '0;
        end else begin
            exp_read_data  = s1_data;
            exp_read_known = s1_known;
            exp_io_rden    = s1_rden;
        end

        // Model still holds only writes presented before this read
        s1_data  = '0;
        s1_known = 1'b0;
        s1_rden  = '0;
        if (rst_n) begin
            if ((read_addr >= read_lo) && (read_addr <= read_hi)) begin
                port     = 32'(read_addr - read_lo);
                s1_data  = io_in[port*word_width +: word_width];
                s1_known = 1'b1;
                s1_rden  = io_read_count'(1) << port;
            end else begin
                s1_data  = model_mem[read_addr];
                s1_known = model_written[read_addr];
            end
        end

        exp_io_wren = '0;
        exp_io_out  = '0;
        if (rst_n) begin
            exp_io_out = {io_write_count{write_data}};
            if (wren && (write_addr >= write_lo) && (write_addr <= write_hi)) begin
                exp_io_wren = io_write_count'(1) << (write_addr - write_lo);
            end
            if (wren) begin
                model_mem[write_addr]     = write_data;
                model_written[write_addr] = 1'b1;
            end
        end
    end

endmodule

/* tb/mmio_memory_tb.sv */
`timescale 1ns/100ps

module mmio_memory_tb;

    localparam int unsigned word_width     = mmio_memory_pkg::word_width_default;
    localparam int unsigned addr_width     = mmio_memory_pkg::addr_width_default;
    localparam int unsigned io_read_count  = mmio_memory_pkg::io_read_count_default;
    localparam int unsigned io_read_base   = mmio_memory_pkg::io_read_base_default;
    localparam int unsigned io_write_count = mmio_memory_pkg::io_write_count_default;
    localparam int unsigned io_write_base  = mmio_memory_pkg::io_write_base_default;

    localparam logic [addr_width-1:0] read_base  = addr_width'(io_read_base);
    localparam logic [addr_width-1:0] write_base = addr_width'(io_write_base);

    // Cycles per test, with the pipeline drain
    localparam int unsigned drain_cycles = 4;
    localparam int unsigned reset_cycles = 3;
    localparam int unsigned ram_cycles   = 64 + 64 + drain_cycles;
    localparam int unsigned out_cycles   = 11 + drain_cycles;
    localparam int unsigned in_cycles    = 12 + drain_cycles;
    localparam int unsigned raw_cycles   = 16 + drain_cycles;
    localparam int unsigned mix_cycles   = 300 + drain_cycles;
    localparam int unsigned cycle_limit  = reset_cycles + ram_cycles + out_cycles
                                         + in_cycles + raw_cycles + mix_cycles + 50;

    logic                                 clock;
    logic                                 rst_n;
    logic                                 wren;
    logic [addr_width-1:0]                write_addr;
    logic [word_width-1:0]                write_data;
    logic [addr_width-1:0]                read_addr;
    logic [word_width*io_read_count-1:0]  io_in;
    logic [word_width-1:0]                read_data;
    logic [io_read_count-1:0]             io_rden;
    logic [io_write_count-1:0]            io_wren;
    logic [word_width*io_write_count-1:0] io_out;

    int unsigned error_count;
    int unsigned read_checks;
    int unsigned cycle_count;
    int unsigned test_number;
    int unsigned tests_passed;
    int unsigned tests_failed;
    int unsigned errors_at_start;
    int unsigned checks_at_start;
    logic [31:0] lfsr_state;

    mmio_memory #(
        .word_width     (word_width),
        .addr_width     (addr_width),
        .io_read_count  (io_read_count),
        .io_read_base   (io_read_base),
        .io_write_count (io_write_count),
        .io_write_base  (io_write_base)
    ) u_mmio_memory (
        .clock      (clock),
        .rst_n      (rst_n),
        .wren       (wren),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .io_in      (io_in),
        .read_data  (read_data),
        .io_rden    (io_rden),
        .io_wren    (io_wren),
        .io_out     (io_out)
    );

    mmio_memory_checker #(
        .word_width     (word_width),
        .addr_width     (addr_width),
        .io_read_count  (io_read_count),
        .io_read_base   (io_read_base),
        .io_write_count (io_write_count),
        .io_write_base  (io_write_base)
    ) u_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .wren        (wren),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .read_addr   (read_addr),
        .io_in       (io_in),
        .read_data   (read_data),
        .io_rden     (io_rden),
        .io_wren     (io_wren),
        .io_out      (io_out),
        .error_count (error_count),
        .read_checks (read_checks)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] take_bits(input int unsigned count);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic random_bit();
        logic [31:0] bits;
        bits = take_bits(1);
        return bits[0];
    endfunction

    function automatic logic [addr_width-1:0] random_addr();
        logic [31:0] bits;
        bits = take_bits(addr_width);
        return bits[addr_width-1:0];
    endfunction

    function automatic logic [word_width-1:0] random_word();
        logic [31:0] bits;
        bits = take_bits(word_width);
        return bits[word_width-1:0];
    endfunction

    // Plain RAM address below the input port window
    function automatic logic [addr_width-1:0] random_ram_addr();
        logic [addr_width-1:0] addr;
        addr = random_addr();
        if (addr >= read_base) begin
            addr[addr_width-1] = 1'b0;
        end
        return addr;
    endfunction

    task automatic step(
        input logic                  we,
        input logic [addr_width-1:0] wa,
        input logic [word_width-1:0] wd,
        input logic [addr_width-1:0] ra
    );
        @(negedge clock);
        wren       = we;
        write_addr = wa;
        write_data = wd;
        read_addr  = ra;
        for (int unsigned p = 0; p < io_read_count; p++) begin
            io_in[p*word_width +: word_width] = random_word();
        end
    endtask

    task automatic begin_test();
        test_number++;
        errors_at_start = error_count;
        checks_at_start = read_checks;
    endtask

    task automatic finish_test(input string name);
        int unsigned errors;
        int unsigned checks;
        repeat (drain_cycles) step(1'b0, '0, '0, '0);
        errors = error_count - errors_at_start;
        checks = read_checks - checks_at_start;
        if (errors != 0) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d mismatches", test_number, name, errors);
        end else if (checks == 0) begin
            tests_failed++;
            $display("test %0d %s: failed, no read result was compared", test_number, name);
        end else begin
            tests_passed++;
            $display("test %0d %s: ok, %0d reads checked", test_number, name, checks);
        end
    endtask

    task automatic run_ram_test();
        logic [addr_width-1:0] addrs [64];
        begin_test();
        for (int i = 0; i < 64; i++) begin
            addrs[i] = random_ram_addr();
            step(1'b1, addrs[i], random_word(), '0);
        end
        for (int i = 0; i < 64; i++) begin
            step(1'b0, '0, '0, addrs[i]);
        end
        finish_test("ram write and read-back");
    endtask

    task automatic run_output_test();
        begin_test();
        for (int unsigned p = 0; p < io_write_count; p++) begin
            step(1'b1, write_base + addr_width'(p), random_word(), '0);
        end
        // Masked and out-of-window writes raise no enable
        for (int unsigned p = 0; p < io_write_count; p++) begin
            step(1'b0, write_base + addr_width'(p), random_word(), '0);
        end
        step(1'b1, write_base - addr_width'(1), random_word(), '0);
        step(1'b1, random_ram_addr(), random_word(), '0);
        for (int unsigned p = 0; p < io_write_count; p++) begin
            step(1'b0, '0, '0, write_base + addr_width'(p));
        end
        finish_test("output ports");
    endtask

    task automatic run_input_test();
        begin_test();
        for (int unsigned i = 0; i < 12; i++) begin
            step(1'b0, '0, '0, read_base + addr_width'(i % io_read_count));
        end
        finish_test("input ports");
    endtask

    task automatic run_raw_test();
        logic [addr_width-1:0] addr;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            addr = random_ram_addr();
            step(1'b1, addr, random_word(), '0);
            step(1'b0, '0, '0, addr);
        end
        finish_test("read after write");
    endtask

    task automatic run_mix_test();
        begin_test();
        for (int i = 0; i < 300; i++) begin
            step(random_bit(), random_addr(), random_word(), random_addr());
        end
        finish_test("random mix");
    endtask

    initial begin
        lfsr_state = 32'h39a8;
        rst_n      = 1'b0;
        wren       = 1'b0;
        write_addr = '0;
        write_data = '0;
        read_addr  = '0;
        io_in      = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        run_ram_test();
        run_output_test();
        run_input_test();
        run_raw_test();
        run_mix_test();

        $display("summary: %0d tests passed, %0d failed, %0d reads checked, %0d mismatches",
                 tests_passed, tests_failed, read_checks, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* mmio_memory.f */
design/mmio_memory_pkg.sv
design/mem_write_decode.sv
design/mem_ram.sv
design/mem_read_result.sv
design/mmio_memory.sv
tb/mmio_memory_props.sv
tb/mmio_memory_checker.sv
tb/mmio_memory_tb.sv

/* Makefile */
# Verilator flow for the MMIO data memory
VERILATOR ?= verilator
TOP       ?= mmio_memory_tb
RTL_TOP   ?= mmio_memory
FILELIST  ?= mmio_memory.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_TEXT ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulation output
sim: build
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -Fqx -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
